//--- source/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path width
`define XLEN        32
// register number width
`define REG_ADDR_W  5
// data memory depth in words, addressed by bits 7:2
`define DMEM_WORDS  64
// multiplier iterations, 2 bits per cycle
`define MUL_STEPS   16

`endif

//--- source/core_pkg.sv
package core_pkg;

  // --------------------------------------------------------------------------
  // alu opcodes
  // --------------------------------------------------------------------------
  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLL   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_SLT   = 4'd8,
    ALU_SLTU  = 4'd9,
    // low word of the product
    ALU_MUL   = 4'd10,
    // high word, both operands unsigned
    ALU_MULHU = 4'd11
  } alu_op_t;

  // --------------------------------------------------------------------------
  // operand, result and forwarding selects
  // --------------------------------------------------------------------------
  typedef enum logic [0:0] {IN2_RS2, IN2_IMM} in2_sel_t;
  typedef enum logic [1:0] {RES_ALU, RES_IMM, RES_LINK} res_sel_t;
  typedef enum logic [1:0] {FWD_REG, FWD_EM, FWD_MW} fwd_sel_t;

endpackage

//--- source/core_regfile.sv
`include "core_macros.svh"

module core_regfile (
  input  logic                   clk,
  input  logic                   rest,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  input  logic                   we,
  input  logic [`REG_ADDR_W-1:0] rd,
  input  logic [`XLEN-1:0]       wdata,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data
);

  localparam int NREGS = 1 << `REG_ADDR_W;

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:NREGS-1];

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // reads return the old value during a write, MEM/WB forwarding covers it
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- source/core_ex_alu.sv
`include "core_macros.svh"

module core_ex_alu (
  input  logic              clk,
  input  logic              rest,
  input  core_pkg::alu_op_t op,
  input  logic              op_valid,
  input  logic [`XLEN-1:0]  in1,
  input  logic [`XLEN-1:0]  in2,
  output logic              op_ready,
  output logic [`XLEN-1:0]  result
);

  import core_pkg::*;

  localparam int W     = `XLEN;
  localparam int CNT_W = $clog2(`MUL_STEPS);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MUL_STEPS - 1);

  typedef enum logic [1:0] {MUL_IDLE, MUL_BUSY, MUL_DONE} mul_state_t;

  mul_state_t       state;
  logic [CNT_W-1:0] step_cnt;
  logic [2*W-1:0]   acc;
  logic [W-1:0]     mcand;
  logic             is_mul;
  logic             mul_start;

  // one radix-4 step: add mc * prod[1:0] to the upper half, then shift right by 2
  function automatic logic [2*W-1:0] mul_step(input logic [2*W-1:0] prod,
                                               input logic [W-1:0]   mc);
    logic [W+1:0] pp;
    logic [W+1:0] sum;
    pp  = ({2'b00, mc} & {(W+2){prod[0]}}) + ({1'b0, mc, 1'b0} & {(W+2){prod[1]}});
    sum = {2'b00, prod[2*W-1:W]} + pp;
    return {sum, prod[W-1:2]};
  endfunction

  assign is_mul    = (op == ALU_MUL) || (op == ALU_MULHU);
  assign mul_start = (state == MUL_IDLE) && op_valid && is_mul;

  // --------------------------------------------------------------------------
  // multiplier control
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state    <= MUL_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        MUL_IDLE: begin
          if (mul_start) begin
            state    <= MUL_BUSY;
            step_cnt <= CNT_W'(1);
          end
        end
        MUL_BUSY: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == LAST_STEP) begin
            state <= MUL_DONE;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  // first step runs on the start edge, so the busy phase needs one less
  always_ff @(posedge clk) begin
    if (mul_start) begin
      acc   <= mul_step({{W{1'b0}}, in2}, in1);
      mcand <= in1;
    end else if (state == MUL_BUSY) begin
      acc <= mul_step(acc, mcand);
    end
  end

  assign op_ready = is_mul ? (state == MUL_DONE) : 1'b1;

  always_comb begin
    case (op)
      ALU_ADD:   result = in1 + in2;
      ALU_SUB:   result = in1 - in2;
      ALU_AND:   result = in1 & in2;
      ALU_OR:    result = in1 | in2;
      ALU_XOR:   result = in1 ^ in2;
      ALU_SLL:   result = in1 << in2[4:0];
      ALU_SRL:   result = in1 >> in2[4:0];
      ALU_SRA:   result = $signed(in1) >>> in2[4:0];
      ALU_SLT:   result = W'($signed(in1) < $signed(in2));
      ALU_SLTU:  result = W'(in1 < in2);
      ALU_MUL:   result = acc[W-1:0];
      ALU_MULHU: result = acc[2*W-1:W];
      default:   result = '0;
    endcase
  end

endmodule

//--- source/core_ex_bypass.sv
`include "core_macros.svh"

module core_ex_bypass (
  input  logic                   [`REG_ADDR_W-1:0] rs1,
  input  logic                   [`REG_ADDR_W-1:0] rs2,
  input  logic                                     rs1_used,
  input  logic                                     rs2_used,
  input  logic                                     em_valid,
  input  logic                   [`REG_ADDR_W-1:0] em_rd,
  input  logic                                     em_reg_write,
  input  logic                                     em_mem_read,
  input  logic                   [`REG_ADDR_W-1:0] mw_rd,
  input  logic                                     mw_reg_write,
  output core_pkg::fwd_sel_t                       rs1_sel,
  output core_pkg::fwd_sel_t                       rs2_sel,
  output logic                                     load_stall
);

  import core_pkg::*;

  logic em_hit1;
  logic em_hit2;
  logic mw_hit1;
  logic mw_hit2;

  // a writer matches a used, nonzero source
  assign em_hit1 = em_valid && em_reg_write && rs1_used && rs1 != '0 && em_rd == rs1;
  assign em_hit2 = em_valid && em_reg_write && rs2_used && rs2 != '0 && em_rd == rs2;
  assign mw_hit1 = mw_reg_write && rs1_used && rs1 != '0 && mw_rd == rs1;
  assign mw_hit2 = mw_reg_write && rs2_used && rs2 != '0 && mw_rd == rs2;

  // youngest writer wins
  always_comb begin
    rs1_sel = FWD_REG;
    if (em_hit1) begin
      rs1_sel = FWD_EM;
    end else if (mw_hit1) begin
      rs1_sel = FWD_MW;
    end
    rs2_sel = FWD_REG;
    if (em_hit2) begin
      rs2_sel = FWD_EM;
    end else if (mw_hit2) begin
      rs2_sel = FWD_MW;
    end
  end

  // load data only exists after MEM, so wait one cycle for the MEM/WB path
  assign load_stall = em_mem_read && (em_hit1 || em_hit2);

endmodule

//--- source/core_ex.sv
`include "core_macros.svh"

module core_ex (
  input  logic                   clk,
  input  logic                   rest,
  // decoded instruction
  input  logic                   de_valid,
  output logic                   de_ready,
  input  core_pkg::alu_op_t      de_alu_op,
  input  core_pkg::in2_sel_t     de_in2_sel,
  input  core_pkg::res_sel_t     de_res_sel,
  input  logic [`REG_ADDR_W-1:0] de_rs1,
  input  logic [`REG_ADDR_W-1:0] de_rs2,
  input  logic                   de_rs1_used,
  input  logic                   de_rs2_used,
  input  logic [`REG_ADDR_W-1:0] de_rd,
  input  logic                   de_reg_write,
  input  logic                   de_mem_read,
  input  logic                   de_mem_write,
  input  logic [`XLEN-1:0]       de_imm,
  input  logic [`XLEN-1:0]       de_pc,
  input  logic                   de_istr_width,
  // register file read data
  input  logic [`XLEN-1:0]       rs1_value,
  input  logic [`XLEN-1:0]       rs2_value,
  // EX/MEM stage
  output logic                   em_valid,
  output logic [`XLEN-1:0]       em_result,
  output logic [`XLEN-1:0]       em_store_data,
  output logic                   em_mem_read,
  output logic                   em_mem_write,
  output logic [`REG_ADDR_W-1:0] em_rd,
  output logic                   em_reg_write,
  // MEM/WB stage, for forwarding
  input  logic [`REG_ADDR_W-1:0] mw_rd,
  input  logic                   mw_reg_write,
  input  logic [`XLEN-1:0]       mw_data
);

  import core_pkg::*;

  fwd_sel_t         rs1_sel;
  fwd_sel_t         rs2_sel;
  logic             load_stall;
  logic             alu_op_valid;
  logic             alu_op_ready;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] rs1_fwd;
  logic [`XLEN-1:0] rs2_fwd;
  logic [`XLEN-1:0] alu_in2;
  logic [`XLEN-1:0] link_addr;
  logic [`XLEN-1:0] ex_result;

  // --------------------------------------------------------------------------
  // operand selection
  // --------------------------------------------------------------------------
  always_comb begin
    case (rs1_sel)
      FWD_EM:  rs1_fwd = em_result;
      FWD_MW:  rs1_fwd = mw_data;
      default: rs1_fwd = rs1_value;
    endcase
    case (rs2_sel)
      FWD_EM:  rs2_fwd = em_result;
      FWD_MW:  rs2_fwd = mw_data;
      default: rs2_fwd = rs2_value;
    endcase
  end

  assign alu_in2   = (de_in2_sel == IN2_IMM) ? de_imm : rs2_fwd;
  // compressed instructions link to pc+2
  assign link_addr = de_pc + (de_istr_width ? `XLEN'd4 : `XLEN'd2);

  always_comb begin
    case (de_res_sel)
      RES_IMM:  ex_result = de_imm;
      RES_LINK: ex_result = link_addr;
      default:  ex_result = alu_out;
    endcase
  end

  // hold off the multiplier until the loaded operand is available
  assign alu_op_valid = de_valid && !load_stall;
  assign de_ready     = alu_op_ready && !load_stall;

  // --------------------------------------------------------------------------
  // EX/MEM registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      em_valid     <= 1'b0;
      em_mem_read  <= 1'b0;
      em_mem_write <= 1'b0;
      em_reg_write <= 1'b0;
    end else begin
      em_valid     <= de_valid && de_ready;
      em_mem_read  <= de_mem_read;
      em_mem_write <= de_mem_write;
      em_reg_write <= de_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    em_result     <= ex_result;
    em_store_data <= rs2_fwd;
    em_rd         <= de_rd;
  end

  core_ex_alu core_ex_alu_inst (
    .clk      (clk),
    .rest     (rest),
    .op       (de_alu_op),
    .op_valid (alu_op_valid),
    .in1      (rs1_fwd),
    .in2      (alu_in2),
    .op_ready (alu_op_ready),
    .result   (alu_out)
  );

  core_ex_bypass core_ex_bypass_inst (
    .rs1          (de_rs1),
    .rs2          (de_rs2),
    .rs1_used     (de_rs1_used),
    .rs2_used     (de_rs2_used),
    .em_valid     (em_valid),
    .em_rd        (em_rd),
    .em_reg_write (em_reg_write),
    .em_mem_read  (em_mem_read),
    .mw_rd        (mw_rd),
    .mw_reg_write (mw_reg_write),
    .rs1_sel      (rs1_sel),
    .rs2_sel      (rs2_sel),
    .load_stall   (load_stall)
  );

endmodule

//--- source/core_mw.sv
`include "core_macros.svh"

module core_mw (
  input  logic                   clk,
  input  logic                   rest,
  input  logic                   em_valid,
  input  logic [`XLEN-1:0]       em_result,
  input  logic [`XLEN-1:0]       em_store_data,
  input  logic                   em_mem_read,
  input  logic                   em_mem_write,
  input  logic [`REG_ADDR_W-1:0] em_rd,
  input  logic                   em_reg_write,
  output logic                   mw_reg_write,
  output logic [`REG_ADDR_W-1:0] mw_rd,
  output logic [`XLEN-1:0]       mw_data
);

  localparam int ADDR_W = $clog2(`DMEM_WORDS);

  logic [`XLEN-1:0]  dmem [`DMEM_WORDS];
  logic [ADDR_W-1:0] word_addr;

  // word addressed, byte offset dropped
  assign word_addr = em_result[ADDR_W+1:2];

  // --------------------------------------------------------------------------
  // data memory
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (em_valid && em_mem_write) begin
      dmem[word_addr] <= em_store_data;
    end
  end

  // --------------------------------------------------------------------------
  // MEM/WB registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      mw_reg_write <= 1'b0;
    end else begin
      mw_reg_write <= em_valid && em_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    mw_rd <= em_rd;
    if (em_valid && em_mem_read) begin
      mw_data <= dmem[word_addr];
    end else begin
      mw_data <= em_result;
    end
  end

endmodule

//--- source/core_ex_top.sv
`include "core_macros.svh"

module core_ex_top (
  input  logic                   clk,
  input  logic                   rest,
  input  logic                   de_valid,
  output logic                   de_ready,
  input  core_pkg::alu_op_t      de_alu_op,
  input  core_pkg::in2_sel_t     de_in2_sel,
  input  core_pkg::res_sel_t     de_res_sel,
  input  logic [`REG_ADDR_W-1:0] de_rs1,
  input  logic [`REG_ADDR_W-1:0] de_rs2,
  input  logic                   de_rs1_used,
  input  logic                   de_rs2_used,
  input  logic [`REG_ADDR_W-1:0] de_rd,
  input  logic                   de_reg_write,
  input  logic                   de_mem_read,
  input  logic                   de_mem_write,
  input  logic [`XLEN-1:0]       de_imm,
  input  logic [`XLEN-1:0]       de_pc,
  input  logic                   de_istr_width,
  // writeback report
  output logic                   wb_valid,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data
);

  logic [`XLEN-1:0]       rs1_value;
  logic [`XLEN-1:0]       rs2_value;
  logic                   em_valid;
  logic [`XLEN-1:0]       em_result;
  logic [`XLEN-1:0]       em_store_data;
  logic                   em_mem_read;
  logic                   em_mem_write;
  logic [`REG_ADDR_W-1:0] em_rd;
  logic                   em_reg_write;
  logic                   mw_reg_write;
  logic [`REG_ADDR_W-1:0] mw_rd;
  logic [`XLEN-1:0]       mw_data;

  // every register write is reported, x0 included
  assign wb_valid = mw_reg_write;
  assign wb_rd    = mw_rd;
  assign wb_data  = mw_data;

  core_regfile core_regfile_inst (
    .clk      (clk),
    .rest     (rest),
    .rs1      (de_rs1),
    .rs2      (de_rs2),
    .we       (mw_reg_write),
    .rd       (mw_rd),
    .wdata    (mw_data),
    .rs1_data (rs1_value),
    .rs2_data (rs2_value)
  );

  core_ex core_ex_inst (
    .clk           (clk),
    .rest          (rest),
    .de_valid      (de_valid),
    .de_ready      (de_ready),
    .de_alu_op     (de_alu_op),
    .de_in2_sel    (de_in2_sel),
    .de_res_sel    (de_res_sel),
    .de_rs1        (de_rs1),
    .de_rs2        (de_rs2),
    .de_rs1_used   (de_rs1_used),
    .de_rs2_used   (de_rs2_used),
    .de_rd         (de_rd),
    .de_reg_write  (de_reg_write),
    .de_mem_read   (de_mem_read),
    .de_mem_write  (de_mem_write),
    .de_imm        (de_imm),
    .de_pc         (de_pc),
    .de_istr_width (de_istr_width),
    .rs1_value     (rs1_value),
    .rs2_value     (rs2_value),
    .em_valid      (em_valid),
    .em_result     (em_result),
    .em_store_data (em_store_data),
    .em_mem_read   (em_mem_read),
    .em_mem_write  (em_mem_write),
    .em_rd         (em_rd),
    .em_reg_write  (em_reg_write),
    .mw_rd         (mw_rd),
    .mw_reg_write  (mw_reg_write),
    .mw_data       (mw_data)
  );

  core_mw core_mw_inst (
    .clk           (clk),
    .rest          (rest),
    .em_valid      (em_valid),
    .em_result     (em_result),
    .em_store_data (em_store_data),
    .em_mem_read   (em_mem_read),
    .em_mem_write  (em_mem_write),
    .em_rd         (em_rd),
    .em_reg_write  (em_reg_write),
    .mw_reg_write  (mw_reg_write),
    .mw_rd         (mw_rd),
    .mw_data       (mw_data)
  );

endmodule

//--- verif/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic rest
);

  timeunit 1ns;
  timeprecision 100ps;

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset held over the first 4 rising edges
  initial begin
    rest = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rest = 1'b1;
  end

endmodule

//--- verif/tb_core_ex.sv
`include "core_macros.svh"

module tb_core_ex;

  timeunit 1ns;
  timeprecision 100ps;

  import core_pkg::*;

  localparam int PERIOD_NS  = 100;
  localparam int N_PER_TEST = 40;
  localparam int N_TESTS    = 6;
  localparam int MAX_CYCLES = N_PER_TEST * N_TESTS * (`MUL_STEPS + 4) + 100;
  localparam int MEM_AW     = $clog2(`DMEM_WORDS);

  // instruction kinds drawn by the generator
  localparam int K_IND   = 0;
  localparam int K_DEP   = 1;
  localparam int K_MUL   = 2;
  localparam int K_STORE = 3;
  localparam int K_LOAD  = 4;
  localparam int K_USE   = 5;
  localparam int K_LINK  = 6;
  localparam int K_LUI   = 7;

  logic                   clk;
  logic                   rest;
  logic                   de_valid;
  logic                   de_ready;
  alu_op_t                de_alu_op;
  in2_sel_t               de_in2_sel;
  res_sel_t               de_res_sel;
  logic [`REG_ADDR_W-1:0] de_rs1;
  logic [`REG_ADDR_W-1:0] de_rs2;
  logic                   de_rs1_used;
  logic                   de_rs2_used;
  logic [`REG_ADDR_W-1:0] de_rd;
  logic                   de_reg_write;
  logic                   de_mem_read;
  logic                   de_mem_write;
  logic [`XLEN-1:0]       de_imm;
  logic [`XLEN-1:0]       de_pc;
  logic                   de_istr_width;
  logic                   wb_valid;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;

  // architectural state of the model
  logic [`XLEN-1:0]       regs_m [32];
  logic [`XLEN-1:0]       mem_m [`DMEM_WORDS];
  logic [`REG_ADDR_W-1:0] recent_rd [2];
  logic [`REG_ADDR_W-1:0] last_load_rd;

  // expected writebacks in retirement order
  logic [`REG_ADDR_W-1:0] exp_rd_q [$];
  logic [`XLEN-1:0]       exp_data_q [$];
  int                     exp_cycle_q [$];
  alu_op_t                exp_op_q [$];

  int cycle = 0;
  int errors = 0;
  int n_instr = 0;
  int ops_issued [16];
  int ops_seen [16];
  bit wb_ok;

  tb_clock tb_clock_inst (
    .clk  (clk),
    .rest (rest)
  );

  core_ex_top core_ex_top_inst (.*);

  always @(posedge clk) cycle <= cycle + 1;

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_wb(input logic [`REG_ADDR_W-1:0] rd, input logic [`XLEN-1:0] data,
                          input int at, input logic [`REG_ADDR_W-1:0] exp_rd,
                          input logic [`XLEN-1:0] exp_data, input int exp_at,
                          output bit ok);
    ok = (rd === exp_rd && data === exp_data && at == exp_at);
    if (!ok) begin
      errors++;
      $display("mismatch at %0t: got x%0d = %h in cycle %0d, expected x%0d = %h in cycle %0d",
               $time, rd, data, at, exp_rd, exp_data, exp_at);
    end
  endtask

  task automatic check_ops(input alu_op_t op, input int seen, input int expected);
    if (seen != expected) begin
      errors++;
      $display("mismatch at %0t: %s retired %0d writebacks, expected %0d",
               $time, op.name(), seen, expected);
    end
  endtask

  task automatic check_stall(input int seen, input int expected);
    if (seen != expected) begin
      errors++;
      $display("mismatch at %0t: de_ready low for %0d cycles, expected %0d",
               $time, seen, expected);
    end
  endtask

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic logic [`XLEN-1:0] model_alu(input alu_op_t op,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
    logic [2*`XLEN-1:0] prod;
    prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
    case (op)
      ALU_ADD:   return a + b;
      ALU_SUB:   return a - b;
      ALU_AND:   return a & b;
      ALU_OR:    return a | b;
      ALU_XOR:   return a ^ b;
      ALU_SLL:   return a << b[4:0];
      ALU_SRL:   return a >> b[4:0];
      ALU_SRA:   return $signed(a) >>> b[4:0];
      ALU_SLT:   return ($signed(a) < $signed(b)) ? 1 : 0;
      ALU_SLTU:  return (a < b) ? 1 : 0;
      ALU_MUL:   return prod[`XLEN-1:0];
      ALU_MULHU: return prod[2*`XLEN-1:`XLEN];
      default:   return '0;
    endcase
  endfunction

  // runs the accepted instruction in order and queues its writeback
  task automatic execute_model();
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] res;
    b   = (de_in2_sel == IN2_IMM) ? de_imm : regs_m[de_rs2];
    res = model_alu(de_alu_op, regs_m[de_rs1], b);
    if (de_res_sel == RES_IMM) res = de_imm;
    if (de_res_sel == RES_LINK) res = de_pc + (de_istr_width ? 4 : 2);
    if (de_mem_write) mem_m[res[MEM_AW+1:2]] = regs_m[de_rs2];
    if (de_mem_read) res = mem_m[res[MEM_AW+1:2]];
    if (de_reg_write) begin
      exp_rd_q.push_back(de_rd);
      exp_data_q.push_back(res);
      exp_cycle_q.push_back(cycle + 2);
      exp_op_q.push_back(de_alu_op);
      ops_issued[int'(de_alu_op)]++;
      if (de_rd != '0) regs_m[de_rd] = res;
    end
    recent_rd[1] = recent_rd[0];
    recent_rd[0] = de_reg_write ? de_rd : '0;
    last_load_rd = de_mem_read ? de_rd : '0;
    n_instr++;
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  // mostly x0 to x7 so that dependences are frequent
  function automatic logic [`REG_ADDR_W-1:0] small_reg();
    return ($urandom_range(7) != 0) ? $urandom_range(7) : $urandom_range(31);
  endfunction

  // immediate that puts base + imm on a word, mostly within the first 8
  function automatic logic [`XLEN-1:0] addr_imm(input logic [`REG_ADDR_W-1:0] base);
    int unsigned word;
    word = ($urandom_range(7) != 0) ? $urandom_range(7) : $urandom_range(`DMEM_WORDS - 1);
    return (word << 2) - regs_m[base];
  endfunction

  task automatic set_instr(input int kind);
    de_alu_op     = alu_op_t'($urandom_range(9));
    de_in2_sel    = $urandom_range(1) ? IN2_RS2 : IN2_IMM;
    de_res_sel    = RES_ALU;
    de_rs1        = small_reg();
    de_rs2        = small_reg();
    de_rd         = small_reg();
    de_reg_write  = 1'b1;
    de_mem_read   = 1'b0;
    de_mem_write  = 1'b0;
    de_imm        = $urandom();
    de_pc         = $urandom() & ~32'h1;
    de_istr_width = $urandom_range(1);
    case (kind)
      K_IND: begin
        de_rd = $urandom_range(31, 16);
        do begin
          de_rs1 = $urandom_range(31, 16);
          de_rs2 = $urandom_range(31, 16);
        end while (de_rs1 == recent_rd[0] || de_rs1 == recent_rd[1] ||
                   de_rs2 == recent_rd[0] || de_rs2 == recent_rd[1]);
      end
      K_DEP: begin
        if ($urandom_range(3) != 0) de_rs1 = recent_rd[0];
        if ($urandom_range(1) != 0) de_rs2 = recent_rd[1];
      end
      K_MUL: begin
        de_alu_op  = $urandom_range(1) ? ALU_MULHU : ALU_MUL;
        de_in2_sel = IN2_RS2;
        if ($urandom_range(1) != 0) de_rs1 = recent_rd[0];
      end
      K_STORE, K_LOAD: begin
        de_alu_op    = ALU_ADD;
        de_in2_sel   = IN2_IMM;
        de_imm       = addr_imm(de_rs1);
        de_reg_write = (kind == K_LOAD);
        de_mem_read  = (kind == K_LOAD);
        de_mem_write = (kind == K_STORE);
        if (kind == K_LOAD) de_rd = $urandom_range(7, 1);
      end
      K_USE: begin
        de_in2_sel = IN2_RS2;
        if ($urandom_range(1) != 0) de_rs1 = last_load_rd;
        else de_rs2 = last_load_rd;
      end
      default: begin
        de_alu_op  = ALU_ADD;
        de_res_sel = (kind == K_LINK) ? RES_LINK : RES_IMM;
      end
    endcase
    de_rs1_used = (de_res_sel == RES_ALU);
    de_rs2_used = (de_res_sel == RES_ALU) && (de_in2_sel == IN2_RS2 || de_mem_write);
  endtask

  // entered 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic run_instr(input int kind, input bit allow_gap);
    int   stalls;
    int   exp_stalls;
    logic load_use;
    if (allow_gap && $urandom_range(7) == 0) begin
      de_valid     = 1'b0;
      last_load_rd = '0;
      @(posedge clk);
      #1;
    end
    set_instr(kind);
    de_valid = 1'b1;
    load_use = last_load_rd != '0 && ((de_rs1_used && de_rs1 == last_load_rd) ||
                                      (de_rs2_used && de_rs2 == last_load_rd));
    exp_stalls = load_use ? 1 : 0;
    if (de_alu_op == ALU_MUL || de_alu_op == ALU_MULHU) exp_stalls += `MUL_STEPS;
    stalls = 0;
    @(negedge clk);
    while (!de_ready) begin
      stalls++;
      @(negedge clk);
    end
    check_stall(stalls, exp_stalls);
    execute_model();
    @(posedge clk);
    #1;
  endtask

  function automatic int pick_kind(input int test, input int i);
    case (test)
      1: return K_IND;
      2: return K_DEP;
      3: return ($urandom_range(2) == 0) ? K_DEP : K_MUL;
      4: return $urandom_range(1) ? K_STORE : K_LOAD;
      5: return (i % 2 == 0) ? K_LOAD : K_USE;
      default: return ($urandom_range(2) == 0) ? K_DEP : ($urandom_range(1) ? K_LINK : K_LUI);
    endcase
  endfunction

  task automatic run_test(input int test, input string name);
    int err0;
    err0 = errors;
    for (int i = 0; i < N_PER_TEST; i++) begin
      run_instr(pick_kind(test, i), !(test == 5 && i % 2 == 1));
    end
    // drain the pipeline
    de_valid     = 1'b0;
    last_load_rd = '0;
    repeat (4) @(posedge clk);
    #1;
    if (exp_rd_q.size() != 0) begin
      errors++;
      $display("%0t: %0d expected writebacks never appeared", $time, exp_rd_q.size());
      exp_rd_q.delete();
      exp_data_q.delete();
      exp_cycle_q.delete();
      exp_op_q.delete();
    end
    $display("test %0d %s: %s, %0d errors", test, name,
             (errors == err0) ? "ok" : "failed", errors - err0);
  endtask

  // --------------------------------------------------------------------------
  // writeback monitor
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (rest && wb_valid) begin
      if (exp_rd_q.size() == 0) begin
        errors++;
        $display("%0t: writeback to x%0d with no instruction outstanding", $time, wb_rd);
      end else begin
        check_wb(wb_rd, wb_data, cycle, exp_rd_q.pop_front(), exp_data_q.pop_front(),
                 exp_cycle_q.pop_front(), wb_ok);
        // only writebacks that matched count toward their opcode
        if (wb_ok) begin
          ops_seen[int'(exp_op_q[0])]++;
        end
        void'(exp_op_q.pop_front());
      end
    end
  end

  initial begin
    #(MAX_CYCLES * PERIOD_NS);
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h38de_7072));
    de_valid      = 1'b0;
    de_alu_op     = ALU_ADD;
    de_in2_sel    = IN2_RS2;
    de_res_sel    = RES_ALU;
    de_rs1        = '0;
    de_rs2        = '0;
    de_rs1_used   = 1'b0;
    de_rs2_used   = 1'b0;
    de_rd         = '0;
    de_reg_write  = 1'b0;
    de_mem_read   = 1'b0;
    de_mem_write  = 1'b0;
    de_imm        = '0;
    de_pc         = '0;
    de_istr_width = 1'b1;
    recent_rd     = '{default: '0};
    last_load_rd  = '0;
    regs_m        = '{default: '0};
    mem_m         = '{default: '0};
    ops_issued    = '{default: 0};
    ops_seen      = '{default: 0};
    @(posedge rest);
    @(posedge clk);
    #1;
    run_test(1, "independent alu");
    run_test(2, "dependent chains");
    run_test(3, "multiply");
    run_test(4, "store and load");
    run_test(5, "load use");
    run_test(6, "link and lui");
    for (int k = 0; k <= int'(ALU_MULHU); k++) begin
      check_ops(alu_op_t'(k), ops_seen[k], ops_issued[k]);
    end
    $display("%0d instructions, %0d tests, %0d errors", n_instr, N_TESTS, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+source
source/core_pkg.sv
source/core_regfile.sv
source/core_ex_alu.sv
source/core_ex_bypass.sv
source/core_ex.sv
source/core_mw.sv
source/core_ex_top.sv
verif/tb_clock.sv
verif/tb_core_ex.sv

//--- Bender.yml
package:
  name: core_ex

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/core_regfile.sv
      - source/core_ex_alu.sv
      - source/core_ex_bypass.sv
      - source/core_ex.sv
      - source/core_mw.sv
      - source/core_ex_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_clock.sv
      - verif/tb_core_ex.sv
